// File: Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_swt16_core
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into $(LOG) and check the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG BUILD_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/regfile.sv
source/decoder.sv
source/execute.sv
source/swt16_core.sv
sim/tb_swt16_core.sv

// File: sim/tb_swt16_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_swt16_core
   import isa_pkg::*;
   import pipe_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   localparam int N_RANDOM   = 60;

   typedef struct packed {
      logic   valid;
      instr_t instr;
   } entry_t;

   logic   clock;
   logic   rst_n;
   logic   instr_valid;
   instr_t instr;
   wb_t    dut_wb;

   entry_t stim [$];
   wb_t    exp_q [$];
   word_t  model_regs [16];
   int     fixed_len;
   logic   table_ready;

   swt16_core i_dut (
      .clock       (clock),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb          (dut_wb)
   );

   always #(CLK_PERIOD / 2) clock = ~clock;

   function automatic entry_t reg_instr(input logic [3:0] op, input reg_idx_t rd,
                                        input reg_idx_t rs1, input reg_idx_t rs2);
      entry_t e;
      e.valid = 1'b1;
      e.instr = instr_t'({op, rd, rs1, rs2});
      return e;
   endfunction

   function automatic entry_t load_imm(input reg_idx_t rd, input logic [7:0] imm);
      entry_t e;
      e.valid = 1'b1;
      e.instr = instr_t'({OP_LDI, rd, imm});
      return e;
   endfunction

   function automatic entry_t drop_valid(input entry_t e);
      entry_t b;
      b = e;
      b.valid = 1'b0;
      return b;
   endfunction

   // Reference model that runs one instruction at a time in program order
   function automatic wb_t predict(input entry_t e);
      wb_t   res;
      word_t a;
      word_t b;
      res = '0;
      a = model_regs[e.instr.operand.regs.rs1];
      b = model_regs[e.instr.operand.regs.rs2];
      res.valid = e.valid;
      res.rd = e.instr.rd;
      case (e.instr.opcode)
         OP_ADD:  res.data = a + b;
         OP_SUB:  res.data = a - b;
         OP_AND:  res.data = a & b;
         OP_OR:   res.data = a | b;
         OP_XOR:  res.data = a ^ b;
         OP_SLL:  res.data = a << b[3:0];
         OP_SRL:  res.data = a >> b[3:0];
         OP_SRA:  res.data = word_t'($signed(a) >>> b[3:0]);
         OP_LDI:  res.data = 16'($signed(e.instr.operand.imm));
         default: res.valid = 1'b0;
      endcase
      if (res.valid) begin
         model_regs[res.rd] = res.data;
      end
      return res;
   endfunction

   task automatic report_mismatch(input string name, input int slot,
                                  input logic [15:0] expected, input logic [15:0] actual);
      $display("CHECK FAILED: %s in slot %0d expected %0h actual %0h",
               name, slot, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
   endtask

   task automatic check_valid(input int slot, input logic expected, input logic actual);
      if (actual !== expected) begin
         report_mismatch("wb.valid", slot, 16'(expected), 16'(actual));
      end
   endtask

   task automatic check_rd(input int slot, input reg_idx_t expected, input reg_idx_t actual);
      if (actual !== expected) begin
         report_mismatch("wb.rd", slot, 16'(expected), 16'(actual));
      end
   endtask

   task automatic check_data(input int slot, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         report_mismatch("wb.data", slot, expected, actual);
      end
   endtask

   task automatic build_table();
      // Reads of registers never written give zero
      stim.push_back(reg_instr(OP_ADD, 4'd1, 4'd2, 4'd3));
      stim.push_back(reg_instr(OP_OR, 4'd0, 4'd15, 4'd0));
      stim.push_back(load_imm(4'd1, 8'h05));
      stim.push_back(load_imm(4'd2, 8'hfe));
      stim.push_back(load_imm(4'd3, 8'h7f));
      stim.push_back(load_imm(4'd4, 8'h80));
      stim.push_back(reg_instr(OP_ADD, 4'd5, 4'd1, 4'd2));
      stim.push_back(reg_instr(OP_SUB, 4'd6, 4'd3, 4'd1));
      stim.push_back(reg_instr(OP_SUB, 4'd7, 4'd1, 4'd3));
      stim.push_back(reg_instr(OP_AND, 4'd8, 4'd3, 4'd4));
      stim.push_back(reg_instr(OP_OR, 4'd9, 4'd3, 4'd4));
      stim.push_back(reg_instr(OP_XOR, 4'd10, 4'd2, 4'd3));
      // Shift by 15 and arithmetic shifts of negative words
      stim.push_back(load_imm(4'd11, 8'h0f));
      stim.push_back(reg_instr(OP_SLL, 4'd12, 4'd1, 4'd11));
      stim.push_back(reg_instr(OP_SRL, 4'd13, 4'd4, 4'd11));
      stim.push_back(reg_instr(OP_SRA, 4'd14, 4'd4, 4'd11));
      stim.push_back(load_imm(4'd15, 8'h03));
      stim.push_back(reg_instr(OP_SRA, 4'd15, 4'd2, 4'd15));
      stim.push_back(reg_instr(OP_SRL, 4'd0, 4'd2, 4'd15));
      // Dependent chain at distance one, two and three
      stim.push_back(load_imm(4'd1, 8'h11));
      stim.push_back(reg_instr(OP_ADD, 4'd2, 4'd1, 4'd1));
      stim.push_back(reg_instr(OP_ADD, 4'd3, 4'd1, 4'd2));
      stim.push_back(reg_instr(OP_ADD, 4'd4, 4'd1, 4'd2));
      stim.push_back(reg_instr(OP_XOR, 4'd5, 4'd4, 4'd3));
      // r6 in both execute and write-back where the newer one must win
      stim.push_back(load_imm(4'd6, 8'h01));
      stim.push_back(load_imm(4'd6, 8'h02));
      stim.push_back(reg_instr(OP_ADD, 4'd7, 4'd6, 4'd6));
      // None of these may touch r6
      stim.push_back(drop_valid(load_imm(4'd6, 8'h55)));
      stim.push_back(reg_instr(OP_NOP, 4'd6, 4'd1, 4'd2));
      stim.push_back(reg_instr(4'hc, 4'd6, 4'd1, 4'd2));
      stim.push_back(reg_instr(4'hf, 4'd6, 4'd3, 4'd4));
      stim.push_back(reg_instr(OP_ADD, 4'd8, 4'd6, 4'd0));
   endtask

   task automatic add_random();
      entry_t      e;
      logic [31:0] r;
      logic [31:0] bits;
      logic [3:0]  op;
      for (int n = 0; n < N_RANDOM; n++) begin
         r = $urandom;
         bits = $urandom;
         // Opcodes 1 to 9 with about one slot in six a bubble
         op = 4'((r % 32'd9) + 32'd1);
         e.valid = (($urandom % 32'd6) != 32'd0);
         e.instr = instr_t'({op, bits[11:0]});
         stim.push_back(e);
      end
   endtask

   initial begin
      wait (table_ready);
      #((fixed_len + N_RANDOM + 10) * CLK_PERIOD);
      $display("Timeout: the run did not finish in %0d clock cycles",
               fixed_len + N_RANDOM + 10);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      wb_t expected;
      table_ready = 1'b0;
      clock = 1'b0;
      rst_n = 1'b0;
      instr_valid = 1'b0;
      instr = '0;
      void'($urandom(32'h8052));
      for (int i = 0; i < 16; i++) begin
         model_regs[i] = '0;
      end
      build_table();
      fixed_len = stim.size();
      add_random();
      foreach (stim[i]) begin
         exp_q.push_back(predict(stim[i]));
      end
      table_ready = 1'b1;

      repeat (2) begin
         @(negedge clock);
         check_valid(-1, 1'b0, dut_wb.valid);
      end
      rst_n = 1'b1;

      // Result of slot i is checked two falling edges after it is driven
      for (int i = 0; i < stim.size() + 2; i++) begin
         @(negedge clock);
         expected = (i >= 2) ? exp_q[i - 2] : '0;
         check_valid(i - 2, expected.valid, dut_wb.valid);
         if (expected.valid) begin
            check_rd(i - 2, expected.rd, dut_wb.rd);
            check_data(i - 2, expected.data, dut_wb.data);
         end
         if (i < stim.size()) begin
            instr_valid = stim[i].valid;
            instr = stim[i].instr;
         end else begin
            instr_valid = 1'b0;
            instr = '0;
         end
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic     clock,
   input  logic     rst_n,
   input  logic     instr_valid,
   input  instr_t   instr,
   output reg_idx_t rd_idx1,
   output reg_idx_t rd_idx2,
   input  word_t    rd_data1,
   input  word_t    rd_data2,
   input  wb_t      fwd,
   input  wb_t      wb,
   output dec_ex_t  dec
);

   alu_op_e alu_op;
   logic    op_ok;
   word_t   src1;
   word_t   src2;
   word_t   imm_ext;
   dec_ex_t dec_d;

   // Newest value wins: execute, then write-back, then register file
   function automatic word_t bypass(input reg_idx_t idx, input word_t rf_data,
                                    input wb_t near, input wb_t far);
      if (near.valid && near.rd == idx) begin
         return near.data;
      end else if (far.valid && far.rd == idx) begin
         return far.data;
      end
      return rf_data;
   endfunction

   always_comb begin
      op_ok  = 1'b1;
      alu_op = ALU_ADD;
      case (instr.opcode)
         OP_ADD:  alu_op = ALU_ADD;
         OP_SUB:  alu_op = ALU_SUB;
         OP_AND:  alu_op = ALU_AND;
         OP_OR:   alu_op = ALU_OR;
         OP_XOR:  alu_op = ALU_XOR;
         OP_SLL:  alu_op = ALU_SLL;
         OP_SRL:  alu_op = ALU_SRL;
         OP_SRA:  alu_op = ALU_SRA;
         OP_LDI:  alu_op = ALU_PASS;
         // NOP and unused codes
         default: op_ok = 1'b0;
      endcase
   end

   assign rd_idx1 = instr.operand.regs.rs1;
   assign rd_idx2 = instr.operand.regs.rs2;

   assign imm_ext = {{8{instr.operand.imm[7]}}, instr.operand.imm};

   assign src1 = bypass(rd_idx1, rd_data1, fwd, wb);
   assign src2 = (instr.opcode == OP_LDI) ? imm_ext : bypass(rd_idx2, rd_data2, fwd, wb);

   always_comb begin
      dec_d.valid = instr_valid && op_ok;
      dec_d.op    = alu_op;
      dec_d.rd    = instr.rd;
      dec_d.src1  = src1;
      dec_d.src2  = src2;
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         dec.valid <= 1'b0;
      end else begin
         dec <= dec_d;
      end
   end

   // Only known ALU ops reach execute
   a_op_known: assert property (
      @(posedge clock) disable iff (!rst_n)
      dec.valid |-> dec.op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                   ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS}
   ) else $error("valid decode bundle with unknown ALU op");

endmodule

`default_nettype wire

// File: source/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic    clock,
   input  logic    rst_n,
   input  dec_ex_t dec,
   output wb_t     fwd,
   output wb_t     wb
);

   word_t      alu_res;
   logic [3:0] shamt;

   assign shamt = dec.src2[3:0];

   always_comb begin
      case (dec.op)
         ALU_ADD:  alu_res = dec.src1 + dec.src2;
         // Subtract as add of the negated second source
         ALU_SUB:  alu_res = dec.src1 + (~dec.src2 + 16'd1);
         ALU_AND:  alu_res = dec.src1 & dec.src2;
         ALU_OR:   alu_res = dec.src1 | dec.src2;
         ALU_XOR:  alu_res = dec.src1 ^ dec.src2;
         ALU_SLL:  alu_res = dec.src1 << shamt;
         ALU_SRL:  alu_res = dec.src1 >> shamt;
         ALU_SRA:  alu_res = word_t'($signed(dec.src1) >>> shamt);
         ALU_PASS: alu_res = dec.src2;
         default:  alu_res = '0;
      endcase
   end

   // Result of the instruction now in execute, for bypass into decode
   always_comb begin
      fwd.valid = dec.valid;
      fwd.rd    = dec.rd;
      fwd.data  = alu_res;
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         wb.valid <= 1'b0;
      end else begin
         wb <= fwd;
      end
   end

   // Every write-back comes from a decoded instruction one cycle earlier
   a_wb_from_dec: assert property (
      @(posedge clock) disable iff (!rst_n)
      wb.valid |-> $past(dec.valid)
   ) else $error("write-back valid without a decoded instruction");

endmodule

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [3:0]  reg_idx_t;
   typedef logic [7:0]  imm_t;

   // Codes 10 to 15 are unused and decode as NOP
   typedef enum logic [3:0] {
      OP_NOP = 4'd0,
      OP_ADD = 4'd1,
      OP_SUB = 4'd2,
      OP_AND = 4'd3,
      OP_OR  = 4'd4,
      OP_XOR = 4'd5,
      OP_SLL = 4'd6,
      OP_SRL = 4'd7,
      OP_SRA = 4'd8,
      OP_LDI = 4'd9
   } opcode_e;

   typedef struct packed {
      reg_idx_t rs1;
      reg_idx_t rs2;
   } reg_src_t;

   // Low byte is either two source indices or an immediate
   typedef union packed {
      reg_src_t regs;
      imm_t     imm;
   } operand_u;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t rd;
      operand_u operand;
   } instr_t;

endpackage

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

   import isa_pkg::*;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASS
   } alu_op_e;

   // Decode to execute bundle, 41 bits
   typedef struct packed {
      logic     valid;
      alu_op_e  op;
      reg_idx_t rd;
      word_t    src1;
      word_t    src2;
   } dec_ex_t;

   // Result record, 21 bits
   // Used for forwarding, write-back and register write
   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
   } wb_t;

endpackage

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic     clock,
   input  logic     rst_n,
   input  reg_idx_t rd_idx1,
   input  reg_idx_t rd_idx2,
   output word_t    rd_data1,
   output word_t    rd_data2,
   input  wb_t      wr
);

   word_t regs [16];

   // Reads see the old value during a write, bypass covers the gap
   assign rd_data1 = regs[rd_idx1];
   assign rd_data2 = regs[rd_idx2];

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.valid) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // Write-back record from execute must be fully known
   a_wr_known: assert property (
      @(posedge clock) disable iff (!rst_n)
      wr.valid |-> !$isunknown({wr.rd, wr.data})
   ) else $error("regfile write with unknown index or data");

endmodule

`default_nettype wire

// File: source/swt16_core.sv
`timescale 1ns/1ps
`default_nettype none

module swt16_core
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic   clock,
   input  logic   rst_n,
   input  logic   instr_valid,
   input  instr_t instr,
   output wb_t    wb
);

   reg_idx_t rd_idx1;
   reg_idx_t rd_idx2;
   word_t    rd_data1;
   word_t    rd_data2;
   dec_ex_t  dec;
   wb_t      fwd;

   decoder decoder_inst (
      .clock       (clock),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .rd_idx1     (rd_idx1),
      .rd_idx2     (rd_idx2),
      .rd_data1    (rd_data1),
      .rd_data2    (rd_data2),
      .fwd         (fwd),
      .wb          (wb),
      .dec         (dec)
   );

   execute execute_inst (
      .clock (clock),
      .rst_n (rst_n),
      .dec   (dec),
      .fwd   (fwd),
      .wb    (wb)
   );

   // Write port driven straight from the registered result
   regfile regfile_inst (
      .clock    (clock),
      .rst_n    (rst_n),
      .rd_idx1  (rd_idx1),
      .rd_idx2  (rd_idx2),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2),
      .wr       (wb)
   );

endmodule

`default_nettype wire
